// ==== Makefile ====
# Verilator build and run for the vc router testbench

VERILATOR ?= verilator
TOP       ?= vc_router_tb
FLAGS     ?= --binary --assert
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
PASS_MSG  := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the simulation output holds the pass message
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
design/router_pkg.sv
design/router_ifs.sv
design/vc_input_buffer.sv
design/switch_allocator.sv
design/vc_credit_tracker.sv
design/vc_assign_stage.sv
design/vc_router.sv
sim/vc_router_tb.sv

// ==== design/router_ifs.sv ====
// router internal interfaces
// buf_head_if carries the vc heads of one input buffer and its read strobe,
// alloc_if carries switch allocation results and the send feedback
`timescale 1ns/1ns

interface buf_head_if;
  import router_pkg::*;

  vc_oh_t                 head_v;
  flit_t [NUM_VC-1:0]     head_flit;
  logic                   read_en;
  vc_oh_t                 read_vc_oh;

  modport buffer (
    output head_v, head_flit,
    input  read_en, read_vc_oh
  );

  modport monitor (
    input head_v, head_flit
  );

  modport reader (
    input  head_flit,
    output read_en, read_vc_oh
  );
endinterface

interface alloc_if;
  import router_pkg::*;

  // per input
  vc_oh_t   [NUM_PORTS-1:0] local_vc_oh;
  logic     [NUM_PORTS-1:0] input_read;
  // per output
  logic     [NUM_PORTS-1:0] out_req_v;
  port_oh_t [NUM_PORTS-1:0] out_grant_oh;
  logic     [NUM_PORTS-1:0] sent;

  modport allocator (
    output local_vc_oh, out_req_v, out_grant_oh,
    input  sent, input_read
  );

  modport assigner (
    input  local_vc_oh, out_req_v, out_grant_oh,
    output sent, input_read
  );
endinterface

// ==== design/router_pkg.sv ====
// router_pkg
// shared widths, port indices and flit types for the three-port
// virtual-channel router tile of the 1-D mesh
package router_pkg;

  // ====================
  // router dimensions
  // ====================
  localparam int NUM_PORTS = 3;
  localparam int NUM_VC    = 2;
  // flits per vc fifo, also the initial downstream credits per vc
  localparam int VC_DEPTH  = 2;
  localparam int X_W       = 3;
  localparam int PAYLOAD_W = 16;

  // port index order on every per-port array
  typedef enum logic [1:0] {
    PORT_WEST  = 2'd0,
    PORT_EAST  = 2'd1,
    PORT_LOCAL = 2'd2
  } port_e;

  // ====================
  // vector types
  // ====================
  typedef logic [0:0]           vc_id_t;
  typedef logic [X_W-1:0]       x_coord_t;
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // destination x in the top bits, payload below
  typedef logic [X_W+PAYLOAD_W-1:0] flit_t;

  typedef logic [$clog2(VC_DEPTH+1)-1:0] credit_cnt_t;

  typedef logic [NUM_PORTS-1:0] port_oh_t;
  typedef logic [NUM_VC-1:0]    vc_oh_t;

endpackage

// ==== design/switch_allocator.sv ====
// switch allocator
// routes each vc head by its destination column, picks one vc per input
// round-robin and grants one requesting input per output round-robin
`timescale 1ns/1ns

module switch_allocator #(
  parameter router_pkg::x_coord_t router_x = '0
) (
  input  logic        clk_i,
  input  logic        reset_i,
  buf_head_if.monitor head [router_pkg::NUM_PORTS],
  alloc_if.allocator  alloc
);
  import router_pkg::*;

  localparam int ARB_W = (NUM_PORTS > NUM_VC) ? NUM_PORTS : NUM_VC;

  vc_oh_t   head_v      [NUM_PORTS];
  port_oh_t vc_route_oh [NUM_PORTS][NUM_VC];
  // route of the vc each input currently presents
  port_oh_t in_req_oh   [NUM_PORTS];
  vc_id_t   last_vc_q   [NUM_PORTS];
  port_e    last_in_q   [NUM_PORTS];

  function automatic port_oh_t route_oh(input x_coord_t dst_x);
    port_oh_t oh;
    oh = '0;
    if (dst_x > router_x) begin
      oh[PORT_EAST] = 1'b1;
    end else if (dst_x < router_x) begin
      oh[PORT_WEST] = 1'b1;
    end else begin
      oh[PORT_LOCAL] = 1'b1;
    end
    return oh;
  endfunction

  // first request after the last winner, n of the ARB_W bits in use
  function automatic logic [ARB_W-1:0] rr_pick(input logic [ARB_W-1:0] req,
                                               input int n, input int last);
    logic [ARB_W-1:0] gnt;
    logic             found;
    int               idx;
    gnt   = '0;
    found = 1'b0;
    for (int k = 1; k <= ARB_W; k++) begin
      idx = (last + k) % n;
      if (k <= n && !found && req[idx]) begin
        gnt[idx] = 1'b1;
        found    = 1'b1;
      end
    end
    return gnt;
  endfunction

  function automatic int oh_to_idx(input logic [ARB_W-1:0] oh);
    int idx;
    idx = 0;
    for (int k = 0; k < ARB_W; k++) begin
      if (oh[k]) idx = k;
    end
    return idx;
  endfunction

  // ====================
  // route computation
  // ====================
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_route
    assign head_v[i] = head[i].head_v;
    for (genvar v = 0; v < NUM_VC; v++) begin : gen_vc
      assign vc_route_oh[i][v] = route_oh(head[i].head_flit[v][PAYLOAD_W +: X_W]);
    end
  end

  // ====================
  // local and global arbitration
  // ====================
  always_comb begin
    logic [ARB_W-1:0] pick;
    logic [ARB_W-1:0] req_in;
    for (int i = 0; i < NUM_PORTS; i++) begin
      pick = rr_pick(ARB_W'(head_v[i]), NUM_VC, int'(last_vc_q[i]));
      alloc.local_vc_oh[i] = pick[NUM_VC-1:0];
      in_req_oh[i] = '0;
      for (int v = 0; v < NUM_VC; v++) begin
        if (pick[v]) in_req_oh[i] = vc_route_oh[i][v];
      end
    end
    for (int o = 0; o < NUM_PORTS; o++) begin
      req_in = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        req_in[i] = in_req_oh[i][o];
      end
      alloc.out_req_v[o] = |req_in;
      pick = rr_pick(req_in, NUM_PORTS, int'(last_in_q[o]));
      alloc.out_grant_oh[o] = pick[NUM_PORTS-1:0];
    end
  end

  // pointers move only on an actual transfer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        last_vc_q[p] <= vc_id_t'(NUM_VC - 1);
        last_in_q[p] <= PORT_LOCAL;
      end
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (alloc.input_read[p]) begin
          last_vc_q[p] <= vc_id_t'(oh_to_idx(ARB_W'(alloc.local_vc_oh[p])));
        end
        if (alloc.sent[p]) begin
          last_in_q[p] <= port_e'(oh_to_idx(ARB_W'(alloc.out_grant_oh[p])));
        end
      end
    end
  end

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_chk
    assert property (@(posedge clk_i) disable iff (reset_i)
      alloc.out_req_v[o] |-> $onehot(alloc.out_grant_oh[o]));
  end

endmodule

// ==== design/vc_assign_stage.sv ====
// vc assignment stage
// joins switch grants with the selected output vc, pops the winning
// buffer head and registers the flit onto the output port
`timescale 1ns/1ns

module vc_assign_stage (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  buf_head_if.reader                                      head [router_pkg::NUM_PORTS],
  alloc_if.assigner                                       alloc,
  input  logic               [router_pkg::NUM_PORTS-1:0] vc_sel_v_i,
  input  router_pkg::vc_id_t [router_pkg::NUM_PORTS-1:0] vc_sel_id_i,
  output logic               [router_pkg::NUM_PORTS-1:0] sent_o,
  output logic               [router_pkg::NUM_PORTS-1:0] data_v_o,
  output router_pkg::vc_id_t [router_pkg::NUM_PORTS-1:0] data_vc_o,
  output router_pkg::flit_t  [router_pkg::NUM_PORTS-1:0] data_o
);
  import router_pkg::*;

  // head flit of the vc picked at each input
  flit_t    [NUM_PORTS-1:0] in_flit;
  flit_t    [NUM_PORTS-1:0] out_flit;
  logic     [NUM_PORTS-1:0] send;
  // per input, which outputs pop it this cycle
  port_oh_t [NUM_PORTS-1:0] rd_by_out;
  logic     [NUM_PORTS-1:0] in_read;

  logic     [NUM_PORTS-1:0] data_v_q;
  vc_id_t   [NUM_PORTS-1:0] data_vc_q;
  flit_t    [NUM_PORTS-1:0] data_q;

  // ====================
  // buffer side
  // ====================
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_in
    always_comb begin
      in_flit[i] = '0;
      for (int v = 0; v < NUM_VC; v++) begin
        if (alloc.local_vc_oh[i][v]) in_flit[i] = head[i].head_flit[v];
      end
    end
    assign head[i].read_en    = in_read[i];
    assign head[i].read_vc_oh = alloc.local_vc_oh[i];
  end

  // ====================
  // output side
  // ====================
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      send[o]     = alloc.out_req_v[o] && vc_sel_v_i[o];
      out_flit[o] = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (alloc.out_grant_oh[o][i]) out_flit[o] = in_flit[i];
      end
    end
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        rd_by_out[i][o] = send[o] && alloc.out_grant_oh[o][i];
      end
      in_read[i] = |rd_by_out[i];
    end
  end

  assign alloc.sent       = send;
  assign alloc.input_read = in_read;
  assign sent_o           = send;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_v_q <= '0;
    end else begin
      data_v_q <= send;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (send[o]) begin
        data_vc_q[o] <= vc_sel_id_i[o];
        data_q[o]    <= out_flit[o];
      end
    end
  end

  assign data_v_o  = data_v_q;
  assign data_vc_o = data_vc_q;
  assign data_o    = data_q;

  // each input requests a single route, so grants never collide on it
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_chk
    assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(rd_by_out[i]));
  end

endmodule

// ==== design/vc_credit_tracker.sv ====
// vc credit tracker
// counts free downstream slots per output vc and offers the
// lowest-index vc that still has a credit
`timescale 1ns/1ns

module vc_credit_tracker (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic               [router_pkg::NUM_PORTS-1:0] credit_v_i,
  input  router_pkg::vc_id_t [router_pkg::NUM_PORTS-1:0] credit_id_i,
  input  logic               [router_pkg::NUM_PORTS-1:0] sent_i,
  output logic               [router_pkg::NUM_PORTS-1:0] vc_sel_v_o,
  output router_pkg::vc_id_t [router_pkg::NUM_PORTS-1:0] vc_sel_id_o
);
  import router_pkg::*;

  credit_cnt_t cnt_q [NUM_PORTS][NUM_VC];
  credit_cnt_t cnt_d [NUM_PORTS][NUM_VC];

  // lowest free vc wins, so scan downwards
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      vc_sel_v_o[o]  = 1'b0;
      vc_sel_id_o[o] = '0;
      for (int v = NUM_VC - 1; v >= 0; v--) begin
        if (cnt_q[o][v] != '0) begin
          vc_sel_v_o[o]  = 1'b1;
          vc_sel_id_o[o] = vc_id_t'(v);
        end
      end
    end
  end

  always_comb begin
    logic inc;
    logic dec;
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int v = 0; v < NUM_VC; v++) begin
        inc = credit_v_i[o] && (int'(credit_id_i[o]) == v);
        dec = sent_i[o] && (int'(vc_sel_id_o[o]) == v);
        cnt_d[o][v] = cnt_q[o][v] + credit_cnt_t'(inc) - credit_cnt_t'(dec);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        for (int v = 0; v < NUM_VC; v++) begin
          cnt_q[o][v] <= credit_cnt_t'(VC_DEPTH);
        end
      end
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // downstream never returns more than it was sent
  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_chk_port
    for (genvar v = 0; v < NUM_VC; v++) begin : gen_chk_vc
      assert property (@(posedge clk_i) disable iff (reset_i)
        cnt_q[o][v] <= credit_cnt_t'(VC_DEPTH));
    end
  end

endmodule

// ==== design/vc_input_buffer.sv ====
// vc input buffer
// registers the incoming flit, then writes it into the fifo of its vc,
// presents every vc head and returns one credit per popped flit
`timescale 1ns/1ns

module vc_input_buffer (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               data_v_i,
  input  router_pkg::vc_id_t data_vc_i,
  input  router_pkg::flit_t  data_i,
  output logic               credit_v_o,
  output router_pkg::vc_id_t credit_id_o,
  buf_head_if.buffer         head
);
  import router_pkg::*;

  localparam int PTR_W = (VC_DEPTH > 1) ? $clog2(VC_DEPTH) : 1;

  logic             in_v_q;
  vc_id_t           in_vc_q;
  flit_t            in_flit_q;

  flit_t            mem_q    [NUM_VC][VC_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q [NUM_VC];
  logic [PTR_W-1:0] rd_ptr_q [NUM_VC];
  credit_cnt_t      cnt_q    [NUM_VC];
  vc_oh_t           push;
  vc_oh_t           pop;

  logic             credit_v_q;
  vc_id_t           credit_id_q;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (int'(p) == VC_DEPTH - 1) ? '0 : p + 1'b1;
  endfunction

  // ====================
  // input stage
  // ====================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_v_q <= 1'b0;
    end else begin
      in_v_q <= data_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    in_vc_q   <= data_vc_i;
    in_flit_q <= data_i;
  end

  // ====================
  // per vc fifos
  // ====================
  for (genvar v = 0; v < NUM_VC; v++) begin : gen_vc
    assign push[v] = in_v_q && (int'(in_vc_q) == v);
    assign pop[v]  = head.read_en && head.read_vc_oh[v];

    assign head.head_v[v]    = (cnt_q[v] != '0);
    assign head.head_flit[v] = mem_q[v][rd_ptr_q[v]];

    always_ff @(posedge clk_i) begin
      if (push[v]) begin
        mem_q[v][wr_ptr_q[v]] <= in_flit_q;
      end
    end

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        wr_ptr_q[v] <= '0;
        rd_ptr_q[v] <= '0;
        cnt_q[v]    <= '0;
      end else begin
        if (push[v]) wr_ptr_q[v] <= ptr_inc(wr_ptr_q[v]);
        if (pop[v])  rd_ptr_q[v] <= ptr_inc(rd_ptr_q[v]);
        cnt_q[v] <= cnt_q[v] + credit_cnt_t'(push[v]) - credit_cnt_t'(pop[v]);
      end
    end

    // upstream only sends into a vc it holds a credit for
    assert property (@(posedge clk_i) disable iff (reset_i)
      push[v] |-> cnt_q[v] != credit_cnt_t'(VC_DEPTH));
  end

  // ====================
  // credit return
  // ====================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_v_q <= 1'b0;
    end else begin
      credit_v_q <= head.read_en;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int v = 0; v < NUM_VC; v++) begin
      if (head.read_vc_oh[v]) credit_id_q <= vc_id_t'(v);
    end
  end

  assign credit_v_o  = credit_v_q;
  assign credit_id_o = credit_id_q;

endmodule

// ==== design/vc_router.sv ====
// vc router tile
// three-port (west, east, local) virtual-channel router for a 1-D mesh
// with credit flow control on every port
`timescale 1ns/1ns

module vc_router #(
  parameter router_pkg::x_coord_t router_x = '0
) (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  // upstream side
  input  logic               [router_pkg::NUM_PORTS-1:0] data_v_i,
  input  router_pkg::vc_id_t [router_pkg::NUM_PORTS-1:0] data_vc_i,
  input  router_pkg::flit_t  [router_pkg::NUM_PORTS-1:0] data_i,
  output logic               [router_pkg::NUM_PORTS-1:0] credit_v_o,
  output router_pkg::vc_id_t [router_pkg::NUM_PORTS-1:0] credit_id_o,
  // downstream side
  output logic               [router_pkg::NUM_PORTS-1:0] data_v_o,
  output router_pkg::vc_id_t [router_pkg::NUM_PORTS-1:0] data_vc_o,
  output router_pkg::flit_t  [router_pkg::NUM_PORTS-1:0] data_o,
  input  logic               [router_pkg::NUM_PORTS-1:0] credit_v_i,
  input  router_pkg::vc_id_t [router_pkg::NUM_PORTS-1:0] credit_id_i
);
  import router_pkg::*;

  buf_head_if head_bus [NUM_PORTS] ();
  alloc_if    alloc_bus ();

  logic   [NUM_PORTS-1:0] vc_sel_v;
  vc_id_t [NUM_PORTS-1:0] vc_sel_id;
  logic   [NUM_PORTS-1:0] sent;

  // ====================
  // input buffers
  // ====================
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_in_buf
    vc_input_buffer u_in_buf (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .data_v_i    (data_v_i[p]),
      .data_vc_i   (data_vc_i[p]),
      .data_i      (data_i[p]),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p]),
      .head        (head_bus[p])
    );
  end

  // allocation and vc selection side by side
  switch_allocator #(
    .router_x (router_x)
  ) u_sw_alloc (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .head    (head_bus),
    .alloc   (alloc_bus)
  );

  vc_credit_tracker u_credit (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i),
    .sent_i      (sent),
    .vc_sel_v_o  (vc_sel_v),
    .vc_sel_id_o (vc_sel_id)
  );

  // ====================
  // assignment and output registers
  // ====================
  vc_assign_stage u_assign (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .head        (head_bus),
    .alloc       (alloc_bus),
    .vc_sel_v_i  (vc_sel_v),
    .vc_sel_id_i (vc_sel_id),
    .sent_o      (sent),
    .data_v_o    (data_v_o),
    .data_vc_o   (data_vc_o),
    .data_o      (data_o)
  );

endmodule

// ==== sim/vc_router_tb.sv ====
// vc router testbench
// drives credit-obeying traffic into all three ports, models the downstream
// credit return and checks routing, ordering, latency and credit accounting
`timescale 1ns/1ns

module vc_router_tb;
  import router_pkg::*;

  localparam x_coord_t ROUTER_X     = 3'd3;
  localparam int       CLK_PERIOD   = 40;
  localparam int       MON_DLY      = 1;
  localparam int       DRV_DLY      = 2;
  localparam int       RESET_CYCLES = 8;
  localparam int       RAND_FLITS   = 200;
  localparam int       SIDE_FLITS   = 4;
  localparam int       CYCLE_LIMIT  = 4000;
  localparam int       LOG_DEPTH    = 512;
  localparam int       SRC_W        = 2;
  localparam int       SEQ_W        = PAYLOAD_W - SRC_W - 1;
  localparam int       SEED         = 32'h8e0a760e;

  logic                   clk_i;
  logic                   reset_i;
  logic   [NUM_PORTS-1:0] data_v_i;
  vc_id_t [NUM_PORTS-1:0] data_vc_i;
  flit_t  [NUM_PORTS-1:0] data_i;
  logic   [NUM_PORTS-1:0] credit_v_o;
  vc_id_t [NUM_PORTS-1:0] credit_id_o;
  logic   [NUM_PORTS-1:0] data_v_o;
  vc_id_t [NUM_PORTS-1:0] data_vc_o;
  flit_t  [NUM_PORTS-1:0] data_o;
  logic   [NUM_PORTS-1:0] credit_v_i;
  vc_id_t [NUM_PORTS-1:0] credit_id_i;

  // stimulus side state
  integer         seed;
  x_coord_t       want_dst [NUM_PORTS];
  int             inj_cnt  [NUM_PORTS][NUM_VC];
  flit_t          sent_log [NUM_PORTS][NUM_VC][LOG_DEPTH];
  logic           any_injected;
  logic           stall_phase;
  port_oh_t       withhold;

  // monitor and downstream side state
  integer         delay_seed;
  int             cyc;
  int             up_ret   [NUM_PORTS][NUM_VC];
  int             rx_seq   [NUM_PORTS][NUM_VC];
  int             ds_out   [NUM_PORTS][NUM_VC];
  int             out_cnt  [NUM_PORTS];
  int             east_seen;
  int             ret_due_q [NUM_PORTS][$];
  int             ret_vc_q  [NUM_PORTS][$];

  vc_router #(
    .router_x (ROUTER_X)
  ) dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .data_v_i    (data_v_i),
    .data_vc_i   (data_vc_i),
    .data_i      (data_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .data_v_o    (data_v_o),
    .data_vc_o   (data_vc_o),
    .data_o      (data_o),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ====================
  // helpers
  // ====================
  task automatic abort_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic report_value_error(input string msg);
    $display("ERROR @ %0t ns: %s", $time, msg);
    abort_run();
  endtask

  // east above our column, west below, local on a match
  function automatic int expected_port(input x_coord_t dst);
    if (dst > ROUTER_X) return int'(PORT_EAST);
    if (dst < ROUTER_X) return int'(PORT_WEST);
    return int'(PORT_LOCAL);
  endfunction

  function automatic logic credit_free(input int p, input int v);
    return (VC_DEPTH - inj_cnt[p][v] + up_ret[p][v]) > 0;
  endfunction

  function automatic logic all_delivered();
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (ret_due_q[p].size() != 0) return 1'b0;
      for (int v = 0; v < NUM_VC; v++) begin
        if (rx_seq[p][v] != inj_cnt[p][v]) return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic wait_cycle();
    @(posedge clk_i);
    #DRV_DLY;
  endtask

  task automatic wait_drained();
    while (!all_delivered()) wait_cycle();
    // last credit reaches the tracker one edge later
    wait_cycle();
  endtask

  // each wanted port sends one flit if it holds a credit
  task automatic inject_cycle(input port_oh_t want_v, input logic rand_vc,
                              output port_oh_t got);
    int       v;
    int       first;
    payload_t pl;
    flit_t    f;
    got = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      v     = -1;
      first = rand_vc ? ($random(seed) & 1) : 0;
      if (want_v[p]) begin
        for (int k = 0; k < NUM_VC; k++) begin
          if (v < 0 && credit_free(p, (first + k) % NUM_VC)) v = (first + k) % NUM_VC;
        end
      end
      if (v >= 0) begin
        pl = {SRC_W'(p), 1'(v), SEQ_W'(inj_cnt[p][v])};
        f  = {want_dst[p], pl};
        sent_log[p][v][inj_cnt[p][v]] = f;
        inj_cnt[p][v]++;
        data_v_i[p]  = 1'b1;
        data_vc_i[p] = vc_id_t'(v);
        data_i[p]    = f;
        got[p]       = 1'b1;
        any_injected = 1'b1;
      end
    end
    wait_cycle();
    data_v_i = '0;
  endtask

  // ====================
  // directed and random phases
  // ====================
  task automatic single_flit_check(input int src, input x_coord_t dst);
    port_oh_t got;
    int       out;
    int       lat;
    wait_drained();
    out           = expected_port(dst);
    want_dst[src] = dst;
    got           = '0;
    while (!got[src]) inject_cycle(port_oh_t'(1 << src), 1'b0, got);
    lat = 0;
    while (!data_v_o[out]) begin
      wait_cycle();
      lat++;
    end
    assert (lat == 2)
      else report_value_error($sformatf("flit from port %0d took %0d cycles", src, lat));
  endtask

  task automatic east_stall_check();
    port_oh_t got;
    port_oh_t want_v;
    int       n_local;
    int       n_west;
    int       n_east;
    int       base_w;
    int       base_l;
    wait_drained();
    withhold[PORT_EAST]   = 1'b1;
    stall_phase           = 1'b1;
    want_dst[PORT_LOCAL]  = 3'd6;
    n_local = 0;
    // more east flits than the east output holds credits for
    while (n_local < 3 * VC_DEPTH) begin
      inject_cycle(port_oh_t'(1 << int'(PORT_LOCAL)), 1'b0, got);
      if (got[PORT_LOCAL]) n_local++;
    end
    while (east_seen < 2 * VC_DEPTH) wait_cycle();
    // west and local outputs keep moving during the stall
    base_w              = out_cnt[PORT_WEST];
    base_l              = out_cnt[PORT_LOCAL];
    want_dst[PORT_WEST] = ROUTER_X;
    want_dst[PORT_EAST] = 3'd0;
    n_west = 0;
    n_east = 0;
    while (n_west < SIDE_FLITS || n_east < SIDE_FLITS) begin
      want_v = '0;
      want_v[PORT_WEST] = (n_west < SIDE_FLITS);
      want_v[PORT_EAST] = (n_east < SIDE_FLITS);
      inject_cycle(want_v, 1'b0, got);
      if (got[PORT_WEST]) n_west++;
      if (got[PORT_EAST]) n_east++;
    end
    while (out_cnt[PORT_LOCAL] < base_l + SIDE_FLITS ||
           out_cnt[PORT_WEST] < base_w + SIDE_FLITS) begin
      wait_cycle();
    end
    stall_phase         = 1'b0;
    withhold[PORT_EAST] = 1'b0;
    wait_drained();
  endtask

  task automatic random_traffic(input int n_flits);
    port_oh_t want_v;
    port_oh_t got;
    int       sent;
    sent = 0;
    while (sent < n_flits) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        want_v[p]   = 1'($random(seed));
        want_dst[p] = x_coord_t'($random(seed));
      end
      inject_cycle(want_v, 1'b1, got);
      sent += $countones(got);
    end
  endtask

  initial begin : stimulus
    seed         = SEED;
    reset_i      = 1'b1;
    data_v_i     = '0;
    data_vc_i    = '0;
    data_i       = '0;
    any_injected = 1'b0;
    stall_phase  = 1'b0;
    withhold     = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      want_dst[p] = '0;
      for (int v = 0; v < NUM_VC; v++) inj_cnt[p][v] = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRV_DLY;
    reset_i = 1'b0;
    // quiet window before the first flit
    repeat (4) wait_cycle();

    single_flit_check(int'(PORT_LOCAL), ROUTER_X);
    single_flit_check(int'(PORT_WEST), 3'd6);
    single_flit_check(int'(PORT_EAST), 3'd0);
    single_flit_check(int'(PORT_WEST), ROUTER_X);
    east_stall_check();
    random_traffic(RAND_FLITS);
    wait_drained();

    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int v = 0; v < NUM_VC; v++) begin
        assert (up_ret[p][v] == inj_cnt[p][v])
          else report_value_error($sformatf("port %0d vc %0d: %0d sent, %0d credits back",
                                            p, v, inj_cnt[p][v], up_ret[p][v]));
      end
    end
    $display("Regression passed");
    $finish;
  end

  // ====================
  // monitor and downstream model
  // ====================
  initial begin : downstream
    int    src;
    int    vc;
    int    sq;
    int    v;
    flit_t f;
    delay_seed  = SEED ^ 32'h0000_5a5a;
    credit_v_i  = '0;
    credit_id_i = '0;
    cyc         = 0;
    east_seen   = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      out_cnt[p] = 0;
      for (int k = 0; k < NUM_VC; k++) begin
        up_ret[p][k] = 0;
        rx_seq[p][k] = 0;
        ds_out[p][k] = 0;
      end
    end
    forever begin
      @(posedge clk_i);
      #MON_DLY;
      cyc++;
      if (cyc >= CYCLE_LIMIT) begin
        $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        abort_run();
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (credit_v_o[p]) begin
          up_ret[p][credit_id_o[p]]++;
          assert (up_ret[p][credit_id_o[p]] <= inj_cnt[p][credit_id_o[p]])
            else report_value_error($sformatf("extra credit on input %0d", p));
        end
      end
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (data_v_o[o]) begin
          f   = data_o[o];
          src = int'(f[PAYLOAD_W-1 -: SRC_W]);
          vc  = int'(f[SEQ_W]);
          sq  = int'(f[SEQ_W-1:0]);
          out_cnt[o]++;
          // each source vc is a fifo, so sequence numbers arrive in order
          assert (src < NUM_PORTS && sq == rx_seq[src][vc])
            else report_value_error($sformatf("port %0d got src %0d vc %0d seq %0d",
                                              o, src, vc, sq));
          assert (f == sent_log[src][vc][sq])
            else report_value_error($sformatf("port %0d flit %h differs from sent %h",
                                              o, f, sent_log[src][vc][sq]));
          rx_seq[src][vc]++;
          ds_out[o][data_vc_o[o]]++;
          ret_due_q[o].push_back(cyc + 1 + ($random(delay_seed) & 3));
          ret_vc_q[o].push_back(int'(data_vc_o[o]));
          if (stall_phase && o == int'(PORT_EAST)) begin
            assert (int'(data_vc_o[o]) == east_seen / VC_DEPTH)
              else report_value_error($sformatf("east flit %0d on vc %0d", east_seen,
                                                data_vc_o[o]));
            east_seen++;
            assert (east_seen <= 2 * VC_DEPTH)
              else report_value_error("east sent with no downstream credit");
          end
        end
        credit_v_i[o] = 1'b0;
        if (!withhold[o] && ret_due_q[o].size() > 0) begin
          if (ret_due_q[o][0] <= cyc) begin
            v              = ret_vc_q[o][0];
            credit_v_i[o]  = 1'b1;
            credit_id_i[o] = vc_id_t'(v);
            ds_out[o][v]--;
            void'(ret_due_q[o].pop_front());
            void'(ret_vc_q[o].pop_front());
          end
        end
      end
      if (!stall_phase) east_seen = 0;
    end
  end

  // ====================
  // concurrent checks
  // ====================
  assert property (@(posedge clk_i) disable iff (reset_i)
    !any_injected |-> (data_v_o == '0) && (credit_v_o == '0))
    else report_value_error("output activity before the first flit");

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_out_chk
    assert property (@(posedge clk_i) disable iff (reset_i)
      data_v_o[o] |-> expected_port(data_o[o][PAYLOAD_W +: X_W]) == o)
      else report_value_error($sformatf("flit for x=%0d left on port %0d",
                                        data_o[o][PAYLOAD_W +: X_W], o));
    for (genvar v = 0; v < NUM_VC; v++) begin : gen_vc_chk
      assert property (@(posedge clk_i) disable iff (reset_i)
        ds_out[o][v] <= VC_DEPTH)
        else report_value_error($sformatf("port %0d vc %0d holds %0d flits downstream",
                                          o, v, ds_out[o][v]));
    end
  end

endmodule
